/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -Wno-fatal
TOP       = bulls_cows_tb
FILELIST  = bulls_cows.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

/* bulls_cows.f */
hdl/bulls_cows_pkg.sv
hdl/secret_gen.sv
hdl/guess_entry.sv
hdl/guess_queue.sv
hdl/bulls_cows_scorer.sv
hdl/bulls_cows_top.sv
verif/bulls_cows_checker.sv
verif/bulls_cows_props.sv
verif/bulls_cows_tb.sv

/* hdl/bulls_cows_pkg.sv */
`default_nettype none

package bulls_cows_pkg;

    // code geometry
    localparam int DIGIT_W    = 4;
    localparam int NUM_DIGITS = 4;
    localparam int POS_W      = $clog2(NUM_DIGITS);

    // random source
    localparam int LFSR_W = 16;

    // guess buffering between entry and scorer
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // one decimal digit, values above 9 are possible on the button input
    typedef logic [DIGIT_W-1:0] digit_t;

    // digit 3 sits in the high nibble
    typedef digit_t [NUM_DIGITS-1:0] code_t;

    // 0..4 matches
    typedef logic [$clog2(NUM_DIGITS+1)-1:0] count_t;

    typedef struct packed {
        count_t bulls;
        count_t cows;
    } score_t;

    // folding constant for out-of-range nibbles
    localparam digit_t DIGIT_BASE = 4'd10;

    // lfsr start value
    localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hACE1;

endpackage

`default_nettype wire

/* hdl/bulls_cows_scorer.sv */
`timescale 1ns/1ps
`default_nettype none

module bulls_cows_scorer
    import bulls_cows_pkg::*;
(
    input  logic   clk,
    input  logic   reset_onepluse,
    input  logic   round_active,
    input  code_t  secret,
    input  code_t  head,
    input  logic   empty,
    output logic   pop,
    output score_t score,
    output logic   score_valid,
    output logic   win
);

    code_t            guess;
    logic             busy;
    logic [POS_W-1:0] pos;
    score_t           acc;
    score_t           acc_next;
    logic             bull_hit;
    logic             cow_hit;
    logic             last_pos;

    // no new guess in the cycle that ends the round
    assign pop = round_active && !busy && !empty && !win;

    assign win = score_valid && (score.bulls == count_t'(NUM_DIGITS));

    assign last_pos = busy && (pos == '0);

    // one secret position per cycle
    always_comb begin
        bull_hit = (secret[pos] == guess[pos]);
        cow_hit  = 1'b0;
        for (int j = 0; j < NUM_DIGITS; j++) begin
            // cow if the secret digit shows up at another guess position
            if ((j != int'(pos)) && (secret[pos] == guess[j])) begin
                cow_hit = 1'b1;
            end
        end
        acc_next.bulls = acc.bulls + count_t'(bull_hit);
        acc_next.cows  = acc.cows + count_t'(cow_hit);
    end

    // sequencing, abandoned as soon as the round closes
    always_ff @(posedge clk) begin
        if (reset_onepluse || !round_active) begin
            busy        <= 1'b0;
            pos         <= '0;
            score_valid <= 1'b0;
        end else begin
            score_valid <= 1'b0;
            if (pop) begin
                busy <= 1'b1;
                pos  <= POS_W'(NUM_DIGITS - 1);
            end else if (last_pos) begin
                busy        <= 1'b0;
                score_valid <= 1'b1;
            end else if (busy) begin
                pos <= pos - 1'b1;
            end
        end
    end

    // popped guess and running totals
    always_ff @(posedge clk) begin
        if (pop) begin
            guess <= head;
            acc   <= '0;
        end else if (busy) begin
            acc <= acc_next;
        end
    end

    // result stays until the next guess is finished
    always_ff @(posedge clk) begin
        if (reset_onepluse) begin
            score <= '0;
        end else if (last_pos && round_active) begin
            score <= acc_next;
        end
    end

endmodule

`default_nettype wire

/* hdl/bulls_cows_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bulls_cows_top
    import bulls_cows_pkg::*;
(
    input  logic   clk,
    input  logic   reset_onepluse,
    input  logic   start,
    input  logic   enter,
    input  digit_t button,
    output logic   round_active,
    output code_t  secret,
    output score_t score,
    output logic   score_valid,
    output logic   win
);

    logic  push;
    code_t push_guess;
    logic  full;
    logic  pop;
    code_t head;
    logic  empty;

    secret_gen secret_gen_i (
        .clk            (clk),
        .reset_onepluse (reset_onepluse),
        .start          (start),
        .win            (win),
        .round_active   (round_active),
        .secret         (secret)
    );

    // producer
    guess_entry guess_entry_i (
        .clk            (clk),
        .reset_onepluse (reset_onepluse),
        .round_active   (round_active),
        .enter          (enter),
        .button         (button),
        .full           (full),
        .push           (push),
        .push_guess     (push_guess)
    );

    guess_queue guess_queue_i (
        .clk            (clk),
        .reset_onepluse (reset_onepluse),
        .round_active   (round_active),
        .push           (push),
        .push_guess     (push_guess),
        .pop            (pop),
        .head           (head),
        .empty          (empty),
        .full           (full)
    );

    // consumer
    bulls_cows_scorer bulls_cows_scorer_i (
        .clk            (clk),
        .reset_onepluse (reset_onepluse),
        .round_active   (round_active),
        .secret         (secret),
        .head           (head),
        .empty          (empty),
        .pop            (pop),
        .score          (score),
        .score_valid    (score_valid),
        .win            (win)
    );

endmodule

`default_nettype wire

/* hdl/guess_entry.sv */
`timescale 1ns/1ps
`default_nettype none

module guess_entry
    import bulls_cows_pkg::*;
(
    input  logic   clk,
    input  logic   reset_onepluse,
    input  logic   round_active,
    input  logic   enter,
    input  digit_t button,
    input  logic   full,
    output logic   push,
    output code_t  push_guess
);

    count_t digit_cnt;
    code_t  guess;
    logic   waiting;
    logic   take_digit;

    // four digits collected, guess is parked until the queue has room
    assign waiting = (digit_cnt == count_t'(NUM_DIGITS));

    // enters while parked are dropped
    assign take_digit = round_active && enter && !waiting;

    // handed over in the first cycle with room
    assign push = round_active && waiting && !full;

    assign push_guess = guess;

    always_ff @(posedge clk) begin
        if (reset_onepluse || !round_active) begin
            digit_cnt <= '0;
        end else if (push) begin
            // queue took it, start the next guess
            digit_cnt <= '0;
        end else if (take_digit) begin
            digit_cnt <= digit_cnt + 1'b1;
        end
    end

    // new digit enters at the low end, first digit ends up as digit 3
    always_ff @(posedge clk) begin
        if (take_digit) begin
            guess <= {guess[NUM_DIGITS-2:0], button};
        end
    end

endmodule

`default_nettype wire

/* hdl/guess_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module guess_queue
    import bulls_cows_pkg::*;
(
    input  logic  clk,
    input  logic  reset_onepluse,
    input  logic  round_active,
    input  logic  push,
    input  code_t push_guess,
    input  logic  pop,
    output code_t head,
    output logic  empty,
    output logic  full
);

    code_t                  mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] occupancy;

    function automatic logic [QUEUE_PTR_W-1:0] ptr_next(input logic [QUEUE_PTR_W-1:0] ptr);
        if (ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty = (occupancy == '0);
    assign full  = (occupancy == QUEUE_CNT_W'(QUEUE_DEPTH));
    assign head  = mem[rd_ptr];

    // pointers and count, flushed between rounds
    always_ff @(posedge clk) begin
        if (reset_onepluse || !round_active) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_guess;
        end
    end

endmodule

`default_nettype wire

/* hdl/secret_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module secret_gen
    import bulls_cows_pkg::*;
(
    input  logic  clk,
    input  logic  reset_onepluse,
    input  logic  start,
    input  logic  win,
    output logic  round_active,
    output code_t secret
);

    logic [LFSR_W-1:0] lfsr;
    logic [LFSR_W-1:0] lfsr_next;
    code_t             raw;
    code_t             folded;
    code_t             candidate;
    logic              distinct;
    logic              open_round;

    // low bit fed back into the upper taps on a right shift
    assign lfsr_next = {lfsr[0],
                        lfsr[15] ^ lfsr[0],
                        lfsr[14] ^ lfsr[0],
                        lfsr[13] ^ lfsr[0],
                        lfsr[12],
                        lfsr[11] ^ lfsr[0],
                        lfsr[10:1]};

    always_ff @(posedge clk) begin
        if (reset_onepluse) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= lfsr_next;
        end
    end

    assign raw = lfsr;

    // fold each nibble into 0..9, then check pairwise distinct
    always_comb begin
        distinct = 1'b1;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (raw[i] >= DIGIT_BASE) begin
                folded[i] = raw[i] - DIGIT_BASE;
            end else begin
                folded[i] = raw[i];
            end
        end
        for (int i = 0; i < NUM_DIGITS; i++) begin
            for (int j = i + 1; j < NUM_DIGITS; j++) begin
                if (folded[i] == folded[j]) begin
                    distinct = 1'b0;
                end
            end
        end
    end

    // latest usable code, refreshed only on a distinct fold
    always_ff @(posedge clk) begin
        if (distinct) begin
            candidate <= folded;
        end
    end

    // a start during a round is ignored
    assign open_round = start && !round_active;

    always_ff @(posedge clk) begin
        if (reset_onepluse) begin
            round_active <= 1'b0;
        end else if (round_active && win) begin
            round_active <= 1'b0;
        end else if (open_round) begin
            round_active <= 1'b1;
        end
    end

    // secret only moves between rounds
    always_ff @(posedge clk) begin
        if (open_round) begin
            secret <= candidate;
        end
    end

endmodule

`default_nettype wire

/* verif/bulls_cows_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module bulls_cows_checker
    import bulls_cows_pkg::*;
(
    input  logic   clk,
    input  logic   reset_onepluse,
    input  logic   round_active,
    input  logic   enter,
    input  digit_t button,
    input  code_t  secret,
    input  score_t score,
    input  logic   score_valid,
    input  logic   win,
    output int     errors,
    output int     pending,
    output int     digits_held
);

    code_t  guesses[$];
    code_t  partial;
    score_t expected;
    logic   win_exp;
    logic   round_q;
    logic   parked;
    logic   push_m;
    logic   pop_m;
    int     queued;
    int     busy_cycles;

    // bulls by position, one cow per secret digit found at another guess position
    function automatic score_t expected_score(input code_t s, input code_t g);
        score_t r;
        logic   hit;
        r = '0;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            hit = 1'b0;
            for (int j = 0; j < NUM_DIGITS; j++) begin
                if (j != i && s[i] == g[j]) begin
                    hit = 1'b1;
                end
            end
            if (s[i] == g[i]) begin
                r.bulls = r.bulls + count_t'(1);
            end
            if (hit) begin
                r.cows = r.cows + count_t'(1);
            end
        end
        return r;
    endfunction

    function automatic logic secret_ok(input code_t s);
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (s[i] > digit_t'(9)) begin
                return 1'b0;
            end
            for (int j = i + 1; j < NUM_DIGITS; j++) begin
                if (s[i] == s[j]) begin
                    return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    always @(posedge clk) begin
        if (reset_onepluse) begin
            errors      = 0;
            digits_held = 0;
            queued      = 0;
            busy_cycles = 0;
            round_q     = 1'b0;
            guesses.delete();
        end else begin
            if (round_active && !round_q && !secret_ok(secret)) begin
                $display("FAILED secret: got %h, expected four distinct digits 0..9", secret);
                errors++;
            end
            if (score_valid) begin
                if (guesses.size() == 0) begin
                    $display("score reported with no guess waiting at %0t", $time);
                    errors++;
                end else begin
                    expected = expected_score(secret, guesses.pop_front());
                    win_exp  = (expected.bulls == count_t'(NUM_DIGITS));
                    if (score !== expected) begin
                        $display("FAILED score: got %h expected %h", score, expected);
                        errors++;
                    end
                    if (win !== win_exp) begin
                        $display("FAILED win: got %h expected %h", win, win_exp);
                        errors++;
                    end
                end
            end else if (win) begin
                $display("win raised without a score at %0t", $time);
                errors++;
            end
            // entry, queue and scorer occupancy as the timing rules give them
            if (!round_active) begin
                digits_held = 0;
                queued      = 0;
                busy_cycles = 0;
                guesses.delete();
            end else begin
                parked = (digits_held == NUM_DIGITS);
                push_m = parked && (queued < QUEUE_DEPTH);
                pop_m  = (busy_cycles == 0) && (queued > 0) && !win;
                queued = queued + int'(push_m) - int'(pop_m);
                if (pop_m) begin
                    busy_cycles = NUM_DIGITS;
                end else if (busy_cycles > 0) begin
                    busy_cycles--;
                end
                if (push_m) begin
                    digits_held = 0;
                end else if (enter && !parked) begin
                    partial = {partial[NUM_DIGITS-2:0], button};
                    digits_held++;
                    if (digits_held == NUM_DIGITS) begin
                        guesses.push_back(partial);
                    end
                end
            end
            round_q = round_active;
        end
        pending = guesses.size();
    end

endmodule

`default_nettype wire

/* verif/bulls_cows_props.sv */
`timescale 1ns/1ps
`default_nettype none

module bulls_cows_props
    import bulls_cows_pkg::*;
(
    input logic                   clk,
    input logic                   reset_onepluse,
    input logic                   push,
    input logic                   pop,
    input logic                   full,
    input logic                   empty,
    input logic [QUEUE_CNT_W-1:0] occupancy
);

    int failures = 0;

    push_has_room: assert property (@(posedge clk) disable iff (reset_onepluse) push |-> !full)
        else begin
            $error("guess queue written while full");
            failures++;
        end

    pop_has_data: assert property (@(posedge clk) disable iff (reset_onepluse) pop |-> !empty)
        else begin
            $error("guess queue read while empty");
            failures++;
        end

    // count never passes the number of slots
    occupancy_bound: assert property (@(posedge clk) disable iff (reset_onepluse)
        occupancy <= QUEUE_CNT_W'(QUEUE_DEPTH))
        else begin
            $error("guess queue occupancy above depth");
            failures++;
        end

endmodule

bind guess_queue bulls_cows_props bulls_cows_props_i (
    .clk            (clk),
    .reset_onepluse (reset_onepluse),
    .push           (push),
    .pop            (pop),
    .full           (full),
    .empty          (empty),
    .occupancy      (occupancy)
);

`default_nettype wire

/* verif/bulls_cows_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bulls_cows_tb
    import bulls_cows_pkg::*;
();

    localparam int          CLK_PERIOD       = 20;
    localparam int          DRIVE_DELAY      = 2;
    localparam int          RESET_CYCLES     = 5;
    localparam logic [31:0] SEED             = 32'hd095_6b34;
    localparam int          BURST_GUESSES    = 8;
    localparam int          SPACED_GUESSES   = 4;
    localparam int          FIXED_GUESSES    = 6;
    localparam int          CYCLES_PER_GUESS = 150;
    localparam int          WAIT_LIMIT       = 300;
    localparam int          WATCHDOG_CYCLES  =
        (BURST_GUESSES + SPACED_GUESSES + FIXED_GUESSES) * CYCLES_PER_GUESS + RESET_CYCLES;

    logic        clk;
    logic        reset_onepluse;
    logic        start;
    logic        enter;
    digit_t      button;
    logic        round_active;
    code_t       secret;
    score_t      score;
    logic        score_valid;
    logic        win;
    int          checker_errors;
    int          pending;
    int          digits_held;
    int          tb_errors;
    int          assert_failures;
    logic [31:0] lfsr_state;
    code_t       guess;

    bulls_cows_top bulls_cows_top_i (
        .clk            (clk),
        .reset_onepluse (reset_onepluse),
        .start          (start),
        .enter          (enter),
        .button         (button),
        .round_active   (round_active),
        .secret         (secret),
        .score          (score),
        .score_valid    (score_valid),
        .win            (win)
    );

    bulls_cows_checker checker_i (
        .clk            (clk),
        .reset_onepluse (reset_onepluse),
        .round_active   (round_active),
        .enter          (enter),
        .button         (button),
        .secret         (secret),
        .score          (score),
        .score_valid    (score_valid),
        .win            (win),
        .errors         (checker_errors),
        .pending        (pending),
        .digits_held    (digits_held)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    // one bit per step of a right-shifting Galois LFSR
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    task automatic enter_digit(input digit_t d, input int gap);
        enter  = 1'b1;
        button = d;
        step();
        enter  = 1'b0;
        idle(gap);
    endtask

    // digit 3 goes in first
    task automatic enter_code(input code_t c, input int gap);
        for (int i = NUM_DIGITS - 1; i >= 0; i--) begin
            enter_digit(c[i], gap);
        end
    endtask

    task automatic wait_round(input logic level);
        int n;
        n = 0;
        while (round_active !== level && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (round_active !== level) begin
            $display("round_active did not reach %0d in time", level);
            tb_errors++;
        end
    endtask

    task automatic open_round();
        start = 1'b1;
        step();
        start = 1'b0;
        wait_round(1'b1);
    endtask

    task automatic wait_scored();
        int n;
        n = 0;
        while (pending != 0 && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (pending != 0) begin
            $display("%0d guesses still unscored after %0d cycles", pending, WAIT_LIMIT);
            tb_errors++;
        end
    endtask

    // pad a partly typed guess so the next one starts at digit 3
    task automatic align_entry();
        while (digits_held != 0) begin
            enter_digit(digit_t'(0), 1);
        end
    endtask

    initial begin
        reset_onepluse = 1'b1;
        start          = 1'b0;
        enter          = 1'b0;
        button         = '0;
        tb_errors      = 0;
        lfsr_state     = SEED;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset_onepluse = 1'b0;
        idle(3);
        // no round open yet
        enter_code(16'h1234, 1);
        idle(10);
        if (round_active !== 1'b0) begin
            $display("FAILED round_active: got %h expected %h", round_active, 1'b0);
            tb_errors++;
        end
        open_round();
        for (int g = 0; g < BURST_GUESSES; g++) begin
            guess = code_t'(take_bits(16));
            enter_code(guess == secret ? guess ^ 16'h0001 : guess, 0);
        end
        wait_scored();
        align_entry();
        wait_scored();
        for (int g = 0; g < SPACED_GUESSES; g++) begin
            guess = code_t'(take_bits(16));
            enter_code(guess == secret ? guess ^ 16'h0001 : guess, int'(take_bits(4)) + 1);
        end
        wait_scored();
        enter_code({secret[3], secret[3], digit_t'(4'hf), secret[0]}, 1);
        enter_code({secret[0], secret[3], secret[2], secret[1]}, 1);
        wait_scored();
        enter_code(secret, 1);
        wait_scored();
        wait_round(1'b0);
        // no score expected while the round is closed
        enter_code(16'h5678, 1);
        idle(20);
        open_round();
        enter_code(secret, 1);
        wait_scored();
        wait_round(1'b0);
        idle(5);
        assert_failures = bulls_cows_top_i.guess_queue_i.bulls_cows_props_i.failures;
        $display("checker errors %0d, testbench errors %0d, assertion failures %0d",
                 checker_errors, tb_errors, assert_failures);
        if (checker_errors + tb_errors + assert_failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
